/* src/udma_cfg_pkg.sv */
// uDMA RX channel configuration package
// Address, transfer size and item types of the linear RX channel,
// the datasize codes and the channel state machine encoding

package udma_cfg_pkg;

    localparam int L2_AWIDTH_NOAL = 16;
    localparam int TRANS_SIZE     = 16;
    localparam int DATA_WIDTH     = 32;

    typedef logic [L2_AWIDTH_NOAL-1:0] l2_addr_t;
    typedef logic [TRANS_SIZE-1:0]     trans_size_t;
    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [1:0]                datasize_t;

    // Item size codes, code 3 behaves as a word
    localparam datasize_t DS_BYTE = 2'd0;
    localparam datasize_t DS_HALF = 2'd1;
    localparam datasize_t DS_WORD = 2'd2;

    typedef enum logic
    {
        CH_IDLE = 1'b0,
        CH_RUN  = 1'b1
    } ch_state_e;

    // Number of bytes carried by one item of the given size
    function automatic trans_size_t item_bytes(datasize_t size);
        case (size)
            DS_BYTE: item_bytes = trans_size_t'(1);
            DS_HALF: item_bytes = trans_size_t'(2);
            default: item_bytes = trans_size_t'(4);
        endcase
    endfunction

endpackage

/* src/udma_l2_pkg.sv */
// uDMA L2 bus package
// Data, byte enable and address types of the L2 req/gnt write bus

package udma_l2_pkg;

    localparam int L2_DATA_WIDTH = 64;
    localparam int L2_BE_WIDTH   = L2_DATA_WIDTH / 8;
    localparam int L2_BUS_AWIDTH = 32;

    // Low address bits that select a byte lane inside one bus word
    localparam int L2_LANE_BITS  = $clog2(L2_BE_WIDTH);

    typedef logic [L2_DATA_WIDTH-1:0] l2_data_t;
    typedef logic [L2_BE_WIDTH-1:0]   l2_be_t;
    typedef logic [L2_BUS_AWIDTH-1:0] l2_bus_addr_t;

endpackage

/* src/udma_rx_fifo.sv */
// uDMA RX item FIFO
// Circular buffer of address-tagged items with a combinational head read

`timescale 1ns/1ps

module udma_rx_fifo
#(
    parameter int unsigned FIFO_DEPTH = 4
)
(
    input  logic                    sys_clk_i,
    input  logic                    rst_n_i,

    input  logic                    push_i,
    input  udma_cfg_pkg::l2_addr_t  push_addr_i,
    input  udma_cfg_pkg::data_t     push_data_i,
    input  udma_cfg_pkg::datasize_t push_size_i,

    input  logic                    pop_i,

    output logic                    full_o,
    output logic                    empty_o,
    output udma_cfg_pkg::l2_addr_t  pop_addr_o,
    output udma_cfg_pkg::data_t     pop_data_o,
    output udma_cfg_pkg::datasize_t pop_size_o
);

    import udma_cfg_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam logic [PTR_W:0] FULL_CNT = (PTR_W+1)'(FIFO_DEPTH);

    l2_addr_t  addr_mem [FIFO_DEPTH];
    data_t     data_mem [FIFO_DEPTH];
    datasize_t size_mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;

    logic do_push;
    logic do_pop;

    assign full_o  = (count_q == FULL_CNT);
    assign empty_o = (count_q == '0);
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // Payload storage
    always_ff @(posedge sys_clk_i)
    begin
        if (do_push)
        begin
            addr_mem[wr_ptr_q] <= push_addr_i;
            data_mem[wr_ptr_q] <= push_data_i;
            size_mem[wr_ptr_q] <= push_size_i;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge sys_clk_i)
    begin
        if (!rst_n_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            if (do_push && !do_pop)
                count_q <= count_q + 1'b1;
            else if (do_pop && !do_push)
                count_q <= count_q - 1'b1;
        end
    end

    assign pop_addr_o = addr_mem[rd_ptr_q];
    assign pop_data_o = data_mem[rd_ptr_q];
    assign pop_size_o = size_mem[rd_ptr_q];

endmodule

/* src/udma_rx_channel_ctrl.sv */
// uDMA linear RX channel controller
// Runs the configured transfer, accepts peripheral items and tags each
// one with its L2 byte address before pushing it into the FIFO

`timescale 1ns/1ps

module udma_rx_channel_ctrl
(
    input  logic                        sys_clk_i,
    input  logic                        rst_n_i,

    input  logic                        rx_lin_valid_i,
    input  udma_cfg_pkg::data_t         rx_lin_data_i,
    input  udma_cfg_pkg::datasize_t     rx_lin_datasize_i,
    output logic                        rx_lin_ready_o,

    input  udma_cfg_pkg::l2_addr_t      rx_lin_cfg_startaddr_i,
    input  udma_cfg_pkg::trans_size_t   rx_lin_cfg_size_i,
    input  logic                        rx_lin_cfg_continuous_i,
    input  logic                        rx_lin_cfg_en_i,
    input  logic                        rx_lin_cfg_clr_i,

    output logic                        rx_lin_events_o,
    output logic                        rx_lin_en_o,
    output logic                        rx_lin_pending_o,
    output udma_cfg_pkg::l2_addr_t      rx_lin_curr_addr_o,
    output udma_cfg_pkg::trans_size_t   rx_lin_bytes_left_o,

    input  logic                        full_i,
    output logic                        push_o,
    output udma_cfg_pkg::l2_addr_t      push_addr_o,
    output udma_cfg_pkg::data_t         push_data_o,
    output udma_cfg_pkg::datasize_t     push_size_o
);

    import udma_cfg_pkg::*;

    ch_state_e   state_q;
    l2_addr_t    curr_addr_q;
    trans_size_t bytes_left_q;
    logic        pending_q;
    logic        continuous_q;
    logic        event_q;

    logic        accept;
    logic        last_item;
    trans_size_t item_size;

    //////////////////////////////////////////////////
    // Peripheral handshake and FIFO push
    //////////////////////////////////////////////////

    assign rx_lin_ready_o = (state_q == CH_RUN) && !full_i;
    assign accept         = rx_lin_valid_i && rx_lin_ready_o;
    assign item_size      = item_bytes(rx_lin_datasize_i);

    // The item that empties the byte count closes the transfer
    assign last_item = (bytes_left_q <= item_size);

    assign push_o      = accept;
    assign push_addr_o = curr_addr_q;
    assign push_data_o = rx_lin_data_i;
    assign push_size_o = rx_lin_datasize_i;

    //////////////////////////////////////////////////
    // Transfer state
    //////////////////////////////////////////////////

    always_ff @(posedge sys_clk_i)
    begin
        if (!rst_n_i)
        begin
            state_q      <= CH_IDLE;
            curr_addr_q  <= '0;
            bytes_left_q <= '0;
            pending_q    <= 1'b0;
            continuous_q <= 1'b0;
            event_q      <= 1'b0;
        end
        else if (rx_lin_cfg_clr_i)
        begin
            state_q   <= CH_IDLE;
            pending_q <= 1'b0;
            event_q   <= 1'b0;
        end
        else
        begin
            event_q <= accept && last_item;
            case (state_q)
                CH_IDLE:
                begin
                    if (rx_lin_cfg_en_i)
                    begin
                        state_q      <= CH_RUN;
                        curr_addr_q  <= rx_lin_cfg_startaddr_i;
                        bytes_left_q <= rx_lin_cfg_size_i;
                        continuous_q <= rx_lin_cfg_continuous_i;
                    end
                end
                CH_RUN:
                begin
                    if (accept && last_item)
                    begin
                        if (continuous_q || pending_q || rx_lin_cfg_en_i)
                        begin
                            // Restart from the configured buffer, channel stays busy
                            curr_addr_q  <= rx_lin_cfg_startaddr_i;
                            bytes_left_q <= rx_lin_cfg_size_i;
                            if (!continuous_q)
                            begin
                                pending_q    <= 1'b0;
                                continuous_q <= rx_lin_cfg_continuous_i;
                            end
                        end
                        else
                        begin
                            state_q      <= CH_IDLE;
                            curr_addr_q  <= curr_addr_q + l2_addr_t'(item_size);
                            bytes_left_q <= '0;
                        end
                    end
                    else
                    begin
                        if (accept)
                        begin
                            curr_addr_q  <= curr_addr_q + l2_addr_t'(item_size);
                            bytes_left_q <= bytes_left_q - item_size;
                        end
                        if (rx_lin_cfg_en_i)
                        begin
                            pending_q <= 1'b1;
                        end
                    end
                end
                default: state_q <= CH_IDLE;
            endcase
        end
    end

    assign rx_lin_events_o     = event_q;
    assign rx_lin_en_o         = (state_q == CH_RUN);
    assign rx_lin_pending_o    = pending_q;
    assign rx_lin_curr_addr_o  = curr_addr_q;
    assign rx_lin_bytes_left_o = bytes_left_q;

endmodule

/* src/udma_l2_write_port.sv */
// uDMA L2 write port
// Places the FIFO head item on its byte lanes and writes it over req/gnt

`timescale 1ns/1ps

module udma_l2_write_port
(
    input  logic                      sys_clk_i,
    input  logic                      rst_n_i,

    input  logic                      empty_i,
    input  udma_cfg_pkg::l2_addr_t    pop_addr_i,
    input  udma_cfg_pkg::data_t       pop_data_i,
    input  udma_cfg_pkg::datasize_t   pop_size_i,
    output logic                      pop_o,

    output logic                      rx_l2_req_o,
    input  logic                      rx_l2_gnt_i,
    output udma_l2_pkg::l2_bus_addr_t rx_l2_addr_o,
    output udma_l2_pkg::l2_be_t       rx_l2_be_o,
    output udma_l2_pkg::l2_data_t     rx_l2_wdata_o
);

    import udma_cfg_pkg::*;
    import udma_l2_pkg::*;

    logic [L2_LANE_BITS-1:0] lane;
    l2_be_t                  size_mask;
    l2_bus_addr_t            head_addr;
    l2_be_t                  head_be;
    l2_data_t                head_wdata;

    //////////////////////////////////////////////////
    // Lane placement of the head item
    //////////////////////////////////////////////////

    assign lane       = pop_addr_i[L2_LANE_BITS-1:0];
    assign size_mask  = l2_be_t'((trans_size_t'(1) << item_bytes(pop_size_i)) - 1'b1);
    assign head_be    = size_mask << lane;
    assign head_wdata = l2_data_t'(pop_data_i) << {lane, 3'b000};
    assign head_addr  = {{(L2_BUS_AWIDTH-L2_AWIDTH_NOAL){1'b0}},
                         pop_addr_i[L2_AWIDTH_NOAL-1:L2_LANE_BITS],
                         {L2_LANE_BITS{1'b0}}};

    // The head entry only changes on a pop, which keeps the request fields stable
    assign rx_l2_req_o   = !empty_i;
    assign rx_l2_addr_o  = head_addr;
    assign rx_l2_be_o    = head_be;
    assign rx_l2_wdata_o = head_wdata;
    assign pop_o         = rx_l2_req_o && rx_l2_gnt_i;

endmodule

/* src/udma_rx_core.sv */
// uDMA linear RX core
// One linear receive channel feeding a FIFO of tagged items,
// drained into L2 memory by a req/gnt write port

`timescale 1ns/1ps

module udma_rx_core
#(
    parameter int unsigned FIFO_DEPTH = 4
)
(
    input  logic                        sys_clk_i,
    input  logic                        rst_n_i,

    input  logic                        rx_lin_valid_i,
    input  udma_cfg_pkg::data_t         rx_lin_data_i,
    input  udma_cfg_pkg::datasize_t     rx_lin_datasize_i,
    output logic                        rx_lin_ready_o,

    input  udma_cfg_pkg::l2_addr_t      rx_lin_cfg_startaddr_i,
    input  udma_cfg_pkg::trans_size_t   rx_lin_cfg_size_i,
    input  logic                        rx_lin_cfg_continuous_i,
    input  logic                        rx_lin_cfg_en_i,
    input  logic                        rx_lin_cfg_clr_i,

    output logic                        rx_lin_events_o,
    output logic                        rx_lin_en_o,
    output logic                        rx_lin_pending_o,
    output udma_cfg_pkg::l2_addr_t      rx_lin_curr_addr_o,
    output udma_cfg_pkg::trans_size_t   rx_lin_bytes_left_o,

    output logic                        rx_l2_req_o,
    input  logic                        rx_l2_gnt_i,
    output udma_l2_pkg::l2_bus_addr_t   rx_l2_addr_o,
    output udma_l2_pkg::l2_be_t         rx_l2_be_o,
    output udma_l2_pkg::l2_data_t       rx_l2_wdata_o
);

    import udma_cfg_pkg::*;

    logic      s_push;
    l2_addr_t  s_push_addr;
    data_t     s_push_data;
    datasize_t s_push_size;
    logic      s_full;

    logic      s_pop;
    logic      s_empty;
    l2_addr_t  s_pop_addr;
    data_t     s_pop_data;
    datasize_t s_pop_size;

    udma_rx_channel_ctrl u_channel
    (
        .sys_clk_i               ( sys_clk_i               ),
        .rst_n_i                 ( rst_n_i                 ),
        .rx_lin_valid_i          ( rx_lin_valid_i          ),
        .rx_lin_data_i           ( rx_lin_data_i           ),
        .rx_lin_datasize_i       ( rx_lin_datasize_i       ),
        .rx_lin_ready_o          ( rx_lin_ready_o          ),
        .rx_lin_cfg_startaddr_i  ( rx_lin_cfg_startaddr_i  ),
        .rx_lin_cfg_size_i       ( rx_lin_cfg_size_i       ),
        .rx_lin_cfg_continuous_i ( rx_lin_cfg_continuous_i ),
        .rx_lin_cfg_en_i         ( rx_lin_cfg_en_i         ),
        .rx_lin_cfg_clr_i        ( rx_lin_cfg_clr_i        ),
        .rx_lin_events_o         ( rx_lin_events_o         ),
        .rx_lin_en_o             ( rx_lin_en_o             ),
        .rx_lin_pending_o        ( rx_lin_pending_o        ),
        .rx_lin_curr_addr_o      ( rx_lin_curr_addr_o      ),
        .rx_lin_bytes_left_o     ( rx_lin_bytes_left_o     ),
        .full_i                  ( s_full                  ),
        .push_o                  ( s_push                  ),
        .push_addr_o             ( s_push_addr             ),
        .push_data_o             ( s_push_data             ),
        .push_size_o             ( s_push_size             )
    );

    udma_rx_fifo
    #(
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) u_fifo (
        .sys_clk_i   ( sys_clk_i   ),
        .rst_n_i     ( rst_n_i     ),
        .push_i      ( s_push      ),
        .push_addr_i ( s_push_addr ),
        .push_data_i ( s_push_data ),
        .push_size_i ( s_push_size ),
        .pop_i       ( s_pop       ),
        .full_o      ( s_full      ),
        .empty_o     ( s_empty     ),
        .pop_addr_o  ( s_pop_addr  ),
        .pop_data_o  ( s_pop_data  ),
        .pop_size_o  ( s_pop_size  )
    );

    udma_l2_write_port u_l2_port
    (
        .sys_clk_i     ( sys_clk_i     ),
        .rst_n_i       ( rst_n_i       ),
        .empty_i       ( s_empty       ),
        .pop_addr_i    ( s_pop_addr    ),
        .pop_data_i    ( s_pop_data    ),
        .pop_size_i    ( s_pop_size    ),
        .pop_o         ( s_pop         ),
        .rx_l2_req_o   ( rx_l2_req_o   ),
        .rx_l2_gnt_i   ( rx_l2_gnt_i   ),
        .rx_l2_addr_o  ( rx_l2_addr_o  ),
        .rx_l2_be_o    ( rx_l2_be_o    ),
        .rx_l2_wdata_o ( rx_l2_wdata_o )
    );

endmodule

/* tests/udma_rx_core_tb.sv */
// uDMA linear RX core testbench
// Applies a table of transfers, answers the L2 bus with optional random stalls
// and checks every L2 write against a queue of the accepted items

`timescale 1ns/1ps

module udma_rx_core_tb;

    import udma_cfg_pkg::*;
    import udma_l2_pkg::*;

    localparam int FIFO_DEPTH     = 4;
    localparam int CLK_HALF       = 4;
    localparam int TIMEOUT_CYCLES = 2000;

    localparam logic [1:0] K_PLAIN   = 2'd0;
    localparam logic [1:0] K_PENDING = 2'd1;
    localparam logic [1:0] K_CLEAR   = 2'd2;

    typedef struct packed
    {
        l2_addr_t    start;
        trans_size_t size;
        datasize_t   dsize;
        logic        continuous;
        logic        stall;
        logic [1:0]  kind;
    } row_t;

    typedef struct packed
    {
        l2_addr_t  addr;
        data_t     data;
        datasize_t size;
    } item_t;

    logic         clk;
    logic         rst_n;
    logic         lin_valid;
    data_t        lin_data;
    datasize_t    lin_datasize;
    logic         lin_ready;
    l2_addr_t     cfg_startaddr;
    trans_size_t  cfg_size;
    logic         cfg_continuous;
    logic         cfg_en;
    logic         cfg_clr;
    logic         lin_events;
    logic         lin_en;
    logic         lin_pending;
    l2_addr_t     lin_curr_addr;
    trans_size_t  lin_bytes_left;
    logic         l2_req;
    logic         l2_gnt;
    l2_bus_addr_t l2_addr;
    l2_be_t       l2_be;
    l2_data_t     l2_wdata;

    row_t        table_q [$];
    item_t       exp_q [$];
    l2_addr_t    drv_addr;
    trans_size_t drv_left;
    int          acc_cnt   = 0;
    int          event_cnt = 0;
    logic        stall_mode;
    integer      data_seed  = 32'h5c949319;
    integer      stall_seed = 32'h5c949319;

    udma_rx_core
    #(
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) dut_i (
        .sys_clk_i               ( clk            ),
        .rst_n_i                 ( rst_n          ),
        .rx_lin_valid_i          ( lin_valid      ),
        .rx_lin_data_i           ( lin_data       ),
        .rx_lin_datasize_i       ( lin_datasize   ),
        .rx_lin_ready_o          ( lin_ready      ),
        .rx_lin_cfg_startaddr_i  ( cfg_startaddr  ),
        .rx_lin_cfg_size_i       ( cfg_size       ),
        .rx_lin_cfg_continuous_i ( cfg_continuous ),
        .rx_lin_cfg_en_i         ( cfg_en         ),
        .rx_lin_cfg_clr_i        ( cfg_clr        ),
        .rx_lin_events_o         ( lin_events     ),
        .rx_lin_en_o             ( lin_en         ),
        .rx_lin_pending_o        ( lin_pending    ),
        .rx_lin_curr_addr_o      ( lin_curr_addr  ),
        .rx_lin_bytes_left_o     ( lin_bytes_left ),
        .rx_l2_req_o             ( l2_req         ),
        .rx_l2_gnt_i             ( l2_gnt         ),
        .rx_l2_addr_o            ( l2_addr        ),
        .rx_l2_be_o              ( l2_be          ),
        .rx_l2_wdata_o           ( l2_wdata       )
    );

    initial
    begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Failure reporting and compare tasks
    //////////////////////////////////////////////////

    task automatic report_failure();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic timeout_failure(input string what);
        $display("Timeout after %0d cycles while waiting for %s", TIMEOUT_CYCLES, what);
        report_failure();
    endtask

    task automatic check_l2_addr(input l2_bus_addr_t exp_val, input l2_bus_addr_t act_val);
        if (act_val !== exp_val)
        begin
            $display("ERR rx_l2_addr_o expected 0x%h actual 0x%h", exp_val, act_val);
            report_failure();
        end
    endtask

    task automatic check_be(input l2_be_t exp_val, input l2_be_t act_val);
        if (act_val !== exp_val)
        begin
            $display("ERR rx_l2_be_o expected 0x%h actual 0x%h", exp_val, act_val);
            report_failure();
        end
    endtask

    task automatic check_wdata(input l2_data_t exp_val, input l2_data_t act_val);
        if (act_val !== exp_val)
        begin
            $display("ERR rx_l2_wdata_o expected 0x%h actual 0x%h", exp_val, act_val);
            report_failure();
        end
    endtask

    task automatic check_curr_addr(input l2_addr_t exp_val, input l2_addr_t act_val);
        if (act_val !== exp_val)
        begin
            $display("ERR rx_lin_curr_addr_o expected 0x%h actual 0x%h", exp_val, act_val);
            report_failure();
        end
    endtask

    task automatic check_bytes_left(input trans_size_t exp_val, input trans_size_t act_val);
        if (act_val !== exp_val)
        begin
            $display("ERR rx_lin_bytes_left_o expected 0x%h actual 0x%h", exp_val, act_val);
            report_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val)
        begin
            $display("ERR %s expected 0x%h actual 0x%h", name, exp_val, act_val);
            report_failure();
        end
    endtask

    task automatic check_count(input string name, input int exp_val, input int act_val);
        if (act_val != exp_val)
        begin
            $display("ERR %s expected 0x%h actual 0x%h", name, exp_val, act_val);
            report_failure();
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // Item size codes 0 and 1 are byte and halfword, 2 and 3 are word
    function automatic int byte_count(input datasize_t s);
        case (s)
            DS_BYTE: return 1;
            DS_HALF: return 2;
            default: return 4;
        endcase
    endfunction

    task automatic check_write(input item_t it);
        int           lane;
        int           nb;
        l2_bus_addr_t exp_addr;
        l2_be_t       exp_be;
        l2_data_t     exp_wdata;
        lane      = int'(it.addr[2:0]);
        nb        = byte_count(it.size);
        exp_addr  = {16'h0000, it.addr[15:3], 3'b000};
        exp_be    = l2_be_t'(((1 << nb) - 1) << lane);
        exp_wdata = l2_data_t'(it.data) << (8 * lane);
        check_l2_addr(exp_addr, l2_addr);
        check_be(exp_be, l2_be);
        check_wdata(exp_wdata, l2_wdata);
    endtask

    // Sampled mid-cycle, so the queue length equals the FIFO fill
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            if (exp_q.size() >= FIFO_DEPTH)
                check_flag("rx_lin_ready_o", 1'b0, lin_ready);
            if (l2_req && l2_gnt)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("An L2 write was granted with no accepted item outstanding");
                    report_failure();
                end
                else
                begin
                    check_write(exp_q.pop_front());
                end
            end
            if (lin_valid && lin_ready)
            begin
                check_curr_addr(drv_addr, lin_curr_addr);
                check_bytes_left(drv_left, lin_bytes_left);
                exp_q.push_back({drv_addr, lin_data, lin_datasize});
                acc_cnt++;
            end
            if (lin_events)
                event_cnt++;
        end
    end

    // L2 responder that grants one cycle in four on average when stalling
    always @(posedge clk)
    begin
        #1;
        if (stall_mode)
            l2_gnt = (($random(stall_seed) & 3) == 0);
        else
            l2_gnt = 1'b1;
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    task automatic next_drive_slot();
        @(posedge clk);
        #1;
    endtask

    task automatic pulse_enable();
        cfg_en = 1'b1;
        next_drive_slot();
        cfg_en = 1'b0;
    endtask

    task automatic pulse_clear();
        cfg_clr = 1'b1;
        next_drive_slot();
        cfg_clr = 1'b0;
    endtask

    task automatic wait_for_enable();
        int waited;
        waited = 0;
        @(negedge clk);
        while (lin_en !== 1'b1)
        begin
            waited++;
            if (waited > TIMEOUT_CYCLES)
                timeout_failure("the channel to start after the enable pulse");
            @(negedge clk);
        end
    endtask

    task automatic send_item(input data_t d, input datasize_t s);
        int start_cnt;
        int waited;
        start_cnt    = acc_cnt;
        waited       = 0;
        lin_valid    = 1'b1;
        lin_data     = d;
        lin_datasize = s;
        while (acc_cnt == start_cnt)
        begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES)
                timeout_failure("the channel to accept a peripheral item");
        end
        #1;
        lin_valid = 1'b0;
    endtask

    task automatic drain_writes();
        int waited;
        waited = 0;
        while (exp_q.size() != 0)
        begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES)
                timeout_failure("the accepted items to be written to L2");
        end
    endtask

    task automatic add_row(input l2_addr_t start, input trans_size_t size,
                           input datasize_t dsize, input logic continuous,
                           input logic stall, input logic [1:0] kind);
        table_q.push_back({start, size, dsize, continuous, stall, kind});
    endtask

    task automatic load_transfer_table();
        add_row(16'h0100, 16'd16, DS_WORD, 1'b0, 1'b0, K_PLAIN);
        add_row(16'h0203, 16'd6,  DS_BYTE, 1'b0, 1'b0, K_PLAIN);
        add_row(16'h0302, 16'd8,  DS_HALF, 1'b0, 1'b1, K_PLAIN);
        add_row(16'h0400, 16'd8,  DS_WORD, 1'b1, 1'b0, K_PLAIN);
        add_row(16'h0500, 16'd32, DS_WORD, 1'b0, 1'b1, K_PLAIN);
        add_row(16'h0600, 16'd16, DS_WORD, 1'b0, 1'b0, K_PENDING);
        add_row(16'h0700, 16'd16, DS_HALF, 1'b0, 1'b1, K_CLEAR);
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial
    begin
        row_t  r;
        int    nb;
        int    passes;
        int    n_items;
        int    offset;
        int    ev_start;
        data_t d;

        rst_n          = 1'b0;
        lin_valid      = 1'b0;
        lin_data       = '0;
        lin_datasize   = DS_WORD;
        cfg_startaddr  = '0;
        cfg_size       = '0;
        cfg_continuous = 1'b0;
        cfg_en         = 1'b0;
        cfg_clr        = 1'b0;
        l2_gnt         = 1'b0;
        stall_mode     = 1'b0;
        drv_addr       = '0;
        drv_left       = '0;
        load_transfer_table();

        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("rx_lin_ready_o", 1'b0, lin_ready);
        check_flag("rx_lin_en_o", 1'b0, lin_en);
        check_flag("rx_lin_pending_o", 1'b0, lin_pending);
        check_flag("rx_lin_events_o", 1'b0, lin_events);
        check_flag("rx_l2_req_o", 1'b0, l2_req);

        for (int k = 0; k < table_q.size(); k++)
        begin
            r       = table_q[k];
            nb      = byte_count(r.dsize);
            passes  = (r.continuous || r.kind == K_PENDING) ? 2 : 1;
            n_items = (r.kind == K_CLEAR) ? 3 : passes * (int'(r.size) / nb);

            next_drive_slot();
            stall_mode     = r.stall;
            cfg_startaddr  = r.start;
            cfg_size       = r.size;
            cfg_continuous = r.continuous;
            ev_start       = event_cnt;
            pulse_enable();
            wait_for_enable();
            next_drive_slot();

            for (int i = 0; i < n_items; i++)
            begin
                // A second enable while running queues one more transfer
                if ((r.kind == K_PENDING || r.kind == K_CLEAR) && i == 1)
                begin
                    pulse_enable();
                    @(negedge clk);
                    check_flag("rx_lin_pending_o", 1'b1, lin_pending);
                    next_drive_slot();
                end
                offset   = (i * nb) % int'(r.size);
                drv_addr = r.start + l2_addr_t'(offset);
                drv_left = r.size - trans_size_t'(offset);
                d        = $random(data_seed);
                d        = d & data_t'((64'd1 << (8 * nb)) - 64'd1);
                send_item(d, r.dsize);
            end

            if (r.kind == K_CLEAR)
            begin
                pulse_clear();
                @(negedge clk);
                check_flag("rx_lin_en_o", 1'b0, lin_en);
                check_flag("rx_lin_pending_o", 1'b0, lin_pending);
            end

            drain_writes();
            // The end event trails the last accepted item by one cycle
            repeat (2) @(posedge clk);
            @(negedge clk);
            check_count("rx_lin_events_o pulse count",
                        (r.kind == K_CLEAR) ? 0 : passes, event_cnt - ev_start);

            if (r.continuous)
            begin
                check_flag("rx_lin_en_o", 1'b1, lin_en);
                next_drive_slot();
                pulse_clear();
                @(negedge clk);
                check_flag("rx_lin_en_o", 1'b0, lin_en);
            end
            else if (r.kind != K_CLEAR)
            begin
                check_flag("rx_lin_en_o", 1'b0, lin_en);
                check_flag("rx_lin_pending_o", 1'b0, lin_pending);
                check_bytes_left('0, lin_bytes_left);
            end
        end

        repeat (4) @(posedge clk);
        if (exp_q.size() == 0)
        begin
            $display("TESTBENCH PASSED");
            $finish;
        end
        else
        begin
            $display("Some accepted items never reached L2");
            report_failure();
        end
    end

endmodule

/* udma_rx_core.f */
src/udma_cfg_pkg.sv
src/udma_l2_pkg.sv
src/udma_rx_fifo.sv
src/udma_rx_channel_ctrl.sv
src/udma_l2_write_port.sv
src/udma_rx_core.sv
tests/udma_rx_core_tb.sv

/* Bender.yml */
package:
  name: udma_rx_core

sources:
  - src/udma_cfg_pkg.sv
  - src/udma_l2_pkg.sv
  - src/udma_rx_fifo.sv
  - src/udma_rx_channel_ctrl.sv
  - src/udma_l2_write_port.sv
  - src/udma_rx_core.sv
  - target: test
    files:
      - tests/udma_rx_core_tb.sv
